// ==== verilog.f ====
+incdir+sim
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_regfile.sv
hw/cpu_alu.sv
hw/cpu_commit.sv
hw/cpu_top.sv
sim/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the CPU testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f verilog.f --top-module cpu_tb -Mdir "$build_dir" -o cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/cpu_tb_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$log_file"; then
    echo "testbench reported a failure, see $log_file"
    exit 1
fi

echo "simulation finished, log in $log_file"
exit 0

// ==== sim/cpu_tb_cases.svh ====
`ifndef cpu_tb_cases_svh
`define cpu_tb_cases_svh

// opcode encoding as the testbench writes instruction words
localparam logic [3:0] code_add   = 4'd0;
localparam logic [3:0] code_sub   = 4'd1;
localparam logic [3:0] code_and   = 4'd2;
localparam logic [3:0] code_or    = 4'd3;
localparam logic [3:0] code_xor   = 4'd4;
localparam logic [3:0] code_shl   = 4'd5;
localparam logic [3:0] code_shr   = 4'd6;
localparam logic [3:0] code_ldi   = 4'd7;
localparam logic [3:0] code_addi  = 4'd8;
localparam logic [3:0] code_cmpeq = 4'd9;
localparam logic [3:0] code_cmplt = 4'd10;
localparam logic [3:0] code_brf   = 4'd11;
localparam logic [3:0] code_ld    = 4'd12;
localparam logic [3:0] code_st    = 4'd13;
localparam logic [3:0] code_halt  = 4'd14;
localparam logic [3:0] code_nop   = 4'd15;

// columns: operation under test, x and y as 16-bit immediates (sign extended
// by op_ldi), and the word the program stores
typedef struct packed {
    logic [3:0]  op;
    logic [15:0] x;
    logic [15:0] y;
    logic [31:0] expected;
} alu_case_t;

localparam int num_cases = 19;

localparam alu_case_t cases [num_cases] = '{
    '{code_add,   16'hffff, 16'h0001, 32'h0000_0000},  // wraps past bit 31
    '{code_add,   16'h1234, 16'h0111, 32'h0000_1345},
    '{code_sub,   16'h0005, 16'h0007, 32'hffff_fffe},
    '{code_and,   16'hf0f0, 16'h0ff0, 32'h0000_00f0},
    '{code_or,    16'h00f0, 16'h0f00, 32'h0000_0ff0},
    '{code_xor,   16'hffff, 16'h00ff, 32'hffff_ff00},
    '{code_shl,   16'h0001, 16'h0014, 32'h0010_0000},  // shift by 20
    '{code_shl,   16'h0003, 16'h0021, 32'h0000_0006},  // only the low five bits count
    '{code_shr,   16'h8000, 16'h0010, 32'h0000_ffff},
    '{code_shr,   16'h0100, 16'h0004, 32'h0000_0010},
    '{code_ldi,   16'h0000, 16'h8001, 32'hffff_8001},
    '{code_addi,  16'h0010, 16'hfff0, 32'h0000_0000},
    '{code_addi,  16'h1000, 16'h0234, 32'h0000_1234},
    '{code_cmpeq, 16'h0042, 16'h0042, 32'h0000_00aa},  // aa marks a taken branch
    '{code_cmpeq, 16'h0042, 16'h0043, 32'h0000_0055},
    '{code_cmplt, 16'hffff, 16'h0001, 32'h0000_00aa},
    '{code_cmplt, 16'h0001, 16'hffff, 32'h0000_0055},
    '{code_cmplt, 16'h0005, 16'h0005, 32'h0000_0055},
    '{code_ld,    16'hbeef, 16'h0000, 32'hffff_beef}
};

`endif

// ==== sim/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    localparam int          clock_period = 8;
    localparam logic [31:0] reset_pc     = 32'd16;
    localparam logic [2:0]  reg_a        = 3'd0;
    localparam logic [2:0]  reg_b        = 3'd1;
    localparam logic [2:0]  reg_c        = 3'd2;
    localparam logic [2:0]  reg_d        = 3'd3;
    localparam logic [2:0]  reg_h        = 3'd7;  // never written, so a zero base
    localparam logic [2:0]  flag_cmp     = 3'd1;

    `include "cpu_tb_cases.svh"

    localparam int watchdog_ns = num_cases * 40 * clock_period;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] data;
    logic [31:0] datao;
    logic [31:0] address;
    logic        rw;
    logic        halted;

    logic [31:0] mem [256];
    logic [31:0] write_addr [$];
    logic [31:0] write_data [$];
    int          prog_len;
    int          errors = 0;

    cpu_top #(
        .RESET_PC (reset_pc)
    ) cpu_top_i (
        .clock   (clock),
        .reset   (reset),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw),
        .halted  (halted)
    );

    always #(clock_period / 2) clock = ~clock;

    assign data = mem[address[7:0]];  // asynchronous read, no wait states

    // ----------------------------------------------------------------------
    // program builder
    function automatic logic [31:0] reg_word(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] ra, input logic [2:0] rb);
        return {op, rd, ra, rb, 19'd0};
    endfunction

    function automatic logic [31:0] imm_word(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] ra, input logic [15:0] imm);
        return {op, rd, ra, 6'd0, imm};
    endfunction

    task automatic fill_memory();
        for (int k = 0; k < 256; k++) begin
            mem[k[7:0]] = {code_nop, 20'd0, k[7:0]};  // a nop carrying its own address
        end
    endtask

    task automatic put_word(input logic [31:0] word);
        logic [7:0] slot;
        slot = reset_pc[7:0] + prog_len[7:0];
        mem[slot] = word;
        prog_len++;
    endtask

    task automatic build_program(input int row, input alu_case_t c);
        logic [15:0] slot_a;
        logic [15:0] slot_b;
        slot_a = 16'(200 + row);
        slot_b = 16'(100 + row);
        fill_memory();
        prog_len = 0;
        put_word(imm_word(code_ldi, reg_a, reg_a, c.x));
        put_word(imm_word(code_ldi, reg_b, reg_a, c.y));
        case (c.op)
            code_ldi:  put_word(imm_word(code_ldi, reg_c, reg_a, c.y));
            code_addi: put_word(imm_word(code_addi, reg_c, reg_a, c.y));
            code_cmpeq, code_cmplt: begin
                put_word(reg_word(c.op, flag_cmp, reg_a, reg_b));
                put_word(imm_word(code_ldi, reg_c, reg_a, 16'h00aa));
                put_word(imm_word(code_brf, reg_a, flag_cmp, 16'd2));  // jumps over the 55
                put_word(imm_word(code_ldi, reg_c, reg_a, 16'h0055));
            end
            code_ld: begin
                put_word(imm_word(code_st, reg_a, reg_h, slot_a));
                put_word(imm_word(code_ld, reg_d, reg_h, slot_a));
                put_word(imm_word(code_st, reg_d, reg_h, slot_b));
            end
            default:   put_word(reg_word(c.op, reg_c, reg_a, reg_b));
        endcase
        if (c.op != code_ld) begin
            put_word(imm_word(code_st, reg_c, reg_h, slot_a));
        end
        put_word(imm_word(code_halt, reg_a, reg_a, 16'd0));
    endtask

    // ----------------------------------------------------------------------
    task automatic check_value(input int row, input string name,
                               input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAIL at %0t: row %0d %s is %h, expected %h",
                     $time, row, name, got, expected);
        end
    endtask

    task automatic run_case(input int row, input alu_case_t c);
        logic [31:0] halt_addr;
        int          expected_writes;
        @(posedge clock);
        reset <= 1'b1;
        build_program(row, c);
        write_addr.delete();
        write_data.delete();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(row, "address after reset", address, reset_pc);
        check_value(row, "rw after reset", 32'(rw), 32'd0);
        check_value(row, "halted after reset", 32'(halted), 32'd0);
        while (halted !== 1'b1) begin
            @(negedge clock);
            if (rw === 1'b1) begin
                mem[address[7:0]] = datao;
                write_addr.push_back(address);
                write_data.push_back(datao);
            end
        end

        // pc parks on the halt word, the last one of the program
        halt_addr = address;
        check_value(row, "address at halt", address, reset_pc + 32'(prog_len) - 32'd1);
        repeat (10) begin
            @(negedge clock);
            check_value(row, "rw after halt", 32'(rw), 32'd0);
            check_value(row, "address after halt", address, halt_addr);
        end

        expected_writes = (c.op == code_ld) ? 2 : 1;
        check_value(row, "write count", 32'(write_addr.size()), 32'(expected_writes));
        if (write_addr.size() >= 1) begin
            check_value(row, "store address", write_addr[0], 32'(200 + row));
            check_value(row, "store data", write_data[0], c.expected);
        end
        if (expected_writes == 2 && write_addr.size() >= 2) begin
            check_value(row, "second store address", write_addr[1], 32'(100 + row));
            check_value(row, "second store data", write_data[1], c.expected);
        end
    endtask

    // ----------------------------------------------------------------------
    initial begin
        fill_memory();
        for (int i = 0; i < num_cases; i++) begin
            run_case(i, cases[i[4:0]]);
        end
        $display("%0d cases run, %0d errors", num_cases, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: the CPU never halted within %0d ns", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire             clock,
    input  wire             reset,
    input  cpu_pkg::word_t  data,
    output cpu_pkg::word_t  datao,
    output cpu_pkg::word_t  address,
    output logic            rw,     // 1 means a write
    output logic            halted
);

    cpu_pkg::ctrl_t  ctrl;
    cpu_pkg::word_t  pc;
    cpu_pkg::state_e state;
    cpu_pkg::exec_t  exec;
    cpu_pkg::wb_t    wb;
    cpu_pkg::word_t  ra_value;
    cpu_pkg::word_t  rb_value;
    cpu_pkg::word_t  rd_value;
    logic            flag_value;

    // --------------------------------------------------------------------
    cpu_fetch #(
        .RESET_PC (RESET_PC)
    ) cpu_fetch_i (
        .clock (clock),
        .reset (reset),
        .data  (data),
        .exec  (exec),
        .ctrl  (ctrl),
        .pc    (pc),
        .state (state)
    );

    cpu_regfile cpu_regfile_i (
        .clock      (clock),
        .reset      (reset),
        .ra_idx     (ctrl.ra),
        .rb_idx     (ctrl.rb),
        .rd_idx     (ctrl.rd),
        .flag_idx   (ctrl.ra),   // op_brf names its flag in ra
        .wb         (wb),
        .ra_value   (ra_value),
        .rb_value   (rb_value),
        .rd_value   (rd_value),
        .flag_value (flag_value)
    );

    cpu_alu cpu_alu_i (
        .ctrl       (ctrl),
        .pc         (pc),
        .ra_value   (ra_value),
        .rb_value   (rb_value),
        .rd_value   (rd_value),
        .flag_value (flag_value),
        .exec       (exec)
    );

    cpu_commit cpu_commit_i (
        .clock   (clock),
        .reset   (reset),
        .state   (state),
        .pc      (pc),
        .exec    (exec),
        .data    (data),
        .wb      (wb),
        .address (address),
        .datao   (datao),
        .rw      (rw),
        .halted  (halted)
    );

endmodule

`default_nettype wire

// ==== hw/cpu_commit.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_commit (
    input  wire                 clock,
    input  wire                 reset,
    input  cpu_pkg::state_e     state,
    input  cpu_pkg::word_t      pc,
    input  cpu_pkg::exec_t      exec,
    input  cpu_pkg::word_t      data,
    output cpu_pkg::wb_t        wb,
    output cpu_pkg::word_t      address,
    output cpu_pkg::word_t      datao,
    output logic                rw,
    output logic                halted
);

    cpu_pkg::word_t    mem_addr_q;
    cpu_pkg::word_t    store_data_q;
    cpu_pkg::reg_idx_t load_idx_q;
    logic              mem_write_q;

    // --------------------------------------------------------------------
    // memory request, taken at the end of exec
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_write_q <= 1'b0;
        end else if (state == cpu_pkg::st_exec && exec.mem_en) begin
            mem_write_q <= exec.mem_write;
        end
    end

    always_ff @(posedge clock) begin
        if (state == cpu_pkg::st_exec && exec.mem_en) begin
            mem_addr_q   <= exec.mem_addr;
            store_data_q <= exec.store_data;
            load_idx_q   <= exec.wb_idx;
        end
    end

    // --------------------------------------------------------------------
    // bus
    assign address = (state == cpu_pkg::st_mem) ? mem_addr_q : pc;
    assign datao   = store_data_q;
    assign rw      = (state == cpu_pkg::st_mem) && mem_write_q;  // one cycle per store
    assign halted  = (state == cpu_pkg::st_halt);

    // writeback comes from the ALU in exec, from the bus for a load
    always_comb begin
        wb = '0;
        if (state == cpu_pkg::st_exec) begin
            wb.reg_en     = exec.wb_en;
            wb.reg_idx    = exec.wb_idx;
            wb.reg_value  = exec.wb_value;
            wb.flag_en    = exec.flag_en;
            wb.flag_idx   = exec.flag_idx;
            wb.flag_value = exec.flag_value;
        end else if (state == cpu_pkg::st_mem) begin
            wb.reg_en    = !mem_write_q;
            wb.reg_idx   = load_idx_q;
            wb.reg_value = data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
    input  cpu_pkg::ctrl_t  ctrl,
    input  cpu_pkg::word_t  pc,
    input  cpu_pkg::word_t  ra_value,
    input  cpu_pkg::word_t  rb_value,
    input  cpu_pkg::word_t  rd_value,
    input  wire             flag_value,
    output cpu_pkg::exec_t  exec
);

    cpu_pkg::word_t operand_b;
    cpu_pkg::word_t sum;

    assign operand_b = ctrl.uses_imm ? ctrl.imm : rb_value;
    assign sum       = ra_value + operand_b;  // shared by add, addi and addressing

    always_comb begin
        exec               = '0;
        exec.wb_idx        = ctrl.rd;
        exec.flag_idx      = ctrl.rd;
        exec.mem_en        = ctrl.is_mem;
        exec.mem_write     = ctrl.is_store;
        exec.mem_addr      = sum;
        exec.store_data    = rd_value;
        exec.branch_target = pc + ctrl.imm;   // word offset from this instruction

        case (ctrl.op)
            cpu_pkg::op_add, cpu_pkg::op_addi: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = sum;
            end
            cpu_pkg::op_sub: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value - operand_b;
            end
            cpu_pkg::op_and: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value & operand_b;
            end
            cpu_pkg::op_or: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value | operand_b;
            end
            cpu_pkg::op_xor: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value ^ operand_b;
            end
            cpu_pkg::op_shl: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value << operand_b[4:0];
            end
            cpu_pkg::op_shr: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ra_value >> operand_b[4:0];  // logical shift
            end
            cpu_pkg::op_ldi: begin
                exec.wb_en    = 1'b1;
                exec.wb_value = ctrl.imm;
            end
            cpu_pkg::op_cmpeq: begin
                exec.flag_en    = 1'b1;
                exec.flag_value = (ra_value == operand_b);
            end
            cpu_pkg::op_cmplt: begin
                exec.flag_en    = 1'b1;
                exec.flag_value = ($signed(ra_value) < $signed(operand_b));
            end
            cpu_pkg::op_brf: begin
                exec.branch_taken = flag_value;
            end
            default: begin
                // loads, stores, halt and nop leave the register file alone here
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpu_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_regfile (
    input  wire                 clock,
    input  wire                 reset,
    input  cpu_pkg::reg_idx_t   ra_idx,
    input  cpu_pkg::reg_idx_t   rb_idx,
    input  cpu_pkg::reg_idx_t   rd_idx,
    input  cpu_pkg::reg_idx_t   flag_idx,
    input  cpu_pkg::wb_t        wb,
    output cpu_pkg::word_t      ra_value,
    output cpu_pkg::word_t      rb_value,
    output cpu_pkg::word_t      rd_value,
    output logic                flag_value
);

    cpu_pkg::word_t regs [8];   // a to h
    logic [7:0]     flags;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (wb.reg_en) begin
                regs[wb.reg_idx] <= wb.reg_value;
            end
            if (wb.flag_en) begin
                flags[wb.flag_idx] <= wb.flag_value;
            end
        end
    end

    // reads return the value from before any write in the same cycle
    assign ra_value   = regs[ra_idx];
    assign rb_value   = regs[rb_idx];
    assign rd_value   = regs[rd_idx];  // store data
    assign flag_value = flags[flag_idx];

endmodule

`default_nettype wire

// ==== hw/cpu_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_fetch #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire                   clock,
    input  wire                   reset,
    input  cpu_pkg::word_t        data,
    input  cpu_pkg::exec_t        exec,
    output cpu_pkg::ctrl_t        ctrl,
    output cpu_pkg::word_t        pc,
    output cpu_pkg::state_e       state
);

    cpu_pkg::instr_u ir;
    logic            imm_form;

    // --------------------------------------------------------------------
    // sequencer and program counter
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= cpu_pkg::st_fetch;
            pc    <= RESET_PC;
        end else begin
            case (state)
                cpu_pkg::st_fetch: begin
                    state <= cpu_pkg::st_exec;
                end
                cpu_pkg::st_exec: begin
                    if (ctrl.is_halt) begin
                        state <= cpu_pkg::st_halt;  // pc holds from here on
                    end else begin
                        pc    <= exec.branch_taken ? exec.branch_target : pc + 32'd1;
                        state <= exec.mem_en ? cpu_pkg::st_mem : cpu_pkg::st_fetch;
                    end
                end
                cpu_pkg::st_mem: begin
                    state <= cpu_pkg::st_fetch;
                end
                default: begin
                    state <= cpu_pkg::st_halt;
                end
            endcase
        end
    end

    // the instruction only lands during fetch, since the bus shows pc there
    always_ff @(posedge clock) begin
        if (state == cpu_pkg::st_fetch) begin
            ir <= data;
        end
    end

    // --------------------------------------------------------------------
    // decode
    always_comb begin
        case (ir.r_view.opcode)
            cpu_pkg::op_ldi, cpu_pkg::op_addi, cpu_pkg::op_brf,
            cpu_pkg::op_ld, cpu_pkg::op_st: imm_form = 1'b1;
            default:                         imm_form = 1'b0;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.op       = ir.r_view.opcode;
        ctrl.uses_imm = imm_form;
        ctrl.rd       = ir.r_view.rd;   // rd and ra sit at the same bits in both views
        ctrl.ra       = ir.r_view.ra;
        if (imm_form) begin
            ctrl.imm = {{16{ir.i_view.imm[15]}}, ir.i_view.imm};
        end else begin
            ctrl.rb = ir.r_view.rb;
        end
        ctrl.is_mem   = (ctrl.op == cpu_pkg::op_ld) || (ctrl.op == cpu_pkg::op_st);
        ctrl.is_store = (ctrl.op == cpu_pkg::op_st);
        ctrl.is_halt  = (ctrl.op == cpu_pkg::op_halt);
    end

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_shl   = 4'd5,
        op_shr   = 4'd6,
        op_ldi   = 4'd7,
        op_addi  = 4'd8,
        op_cmpeq = 4'd9,
        op_cmplt = 4'd10,  // signed compare
        op_brf   = 4'd11,
        op_ld    = 4'd12,
        op_st    = 4'd13,
        op_halt  = 4'd14,
        op_nop   = 4'd15
    } opcode_e;

    // --------------------------------------------------------------------
    // instruction word, read as register form or immediate form
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        logic [18:0] unused;
    } instr_reg_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;     // source of the stored value for op_st
        reg_idx_t    ra;     // flag number for op_brf
        logic [5:0]  unused;
        logic [15:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r_view;
        instr_imm_t i_view;
    } instr_u;

    // --------------------------------------------------------------------
    typedef struct packed {
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    imm;       // already sign extended
        logic     uses_imm;
        logic     is_mem;
        logic     is_store;
        logic     is_halt;
    } ctrl_t;

    typedef struct packed {
        logic     wb_en;
        reg_idx_t wb_idx;
        word_t    wb_value;
        logic     flag_en;
        reg_idx_t flag_idx;
        logic     flag_value;
        logic     mem_en;
        logic     mem_write;
        word_t    mem_addr;
        word_t    store_data;
        logic     branch_taken;
        word_t    branch_target;
    } exec_t;

    typedef struct packed {
        logic     reg_en;
        reg_idx_t reg_idx;
        word_t    reg_value;
        logic     flag_en;
        reg_idx_t flag_idx;
        logic     flag_value;
    } wb_t;

    typedef enum logic [1:0] {
        st_fetch = 2'd0,
        st_exec  = 2'd1,
        st_mem   = 2'd2,
        st_halt  = 2'd3
    } state_e;

endpackage

`default_nettype wire
